// ==== common/clint_consts.svh ====
// ----------------------------------------
// CLINT sizing and register map constants
// Offsets are byte offsets within the CLINT window
// CLINT_PRESCALE must be 2 or more
// ----------------------------------------
`ifndef CLINT_CONSTS_SVH
`define CLINT_CONSTS_SVH

// Harts served, one mtimecmp and one irq each
`define CLINT_NUM_HARTS     4
// Bits needed to index a hart
`define CLINT_HART_WIDTH    2

// Byte offset bits decoded inside the CLINT
`define CLINT_ADDR_WIDTH    6
// Bus data width
`define CLINT_XLEN          32

// Clock cycles per mtime increment
`define CLINT_PRESCALE      20

// Register map
`define CLINT_MTIME_LO_OFS  'h00
`define CLINT_MTIME_HI_OFS  'h04
// Hart h low word at base + 8*h, high word 4 bytes above
`define CLINT_CMP_BASE_OFS  'h08

// Reset values
`define CLINT_MTIME_RESET   64'h0
`define CLINT_CMP_RESET     {64{1'b1}}

`endif

// ==== common/clint_pkg.sv ====
// ----------------------------------------
// Bus and internal strobe types of the CLINT
// Strobe vectors are sized by CLINT_NUM_HARTS
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

package clint_pkg;

    // ----------------------------------------
    // Data bus peripheral port
    // ----------------------------------------

    // Request from the data bus, qualified by the select line
    typedef struct packed {
        logic                    req;
        logic                    w_en;
        logic [31:0]             addr;
        logic [`CLINT_XLEN-1:0]  w_data;
    } dbus2peri_s;

    // Response, ack is a one-cycle pulse
    typedef struct packed {
        logic                    ack;
        logic [`CLINT_XLEN-1:0]  r_data;
    } peri2dbus_s;

    // ----------------------------------------
    // Internal decode results
    // ----------------------------------------

    // Kind of register an offset maps to
    typedef enum logic [2:0] {
        REG_MTIME_LO,
        REG_MTIME_HI,
        REG_CMP_LO,
        REG_CMP_HI,
        REG_NONE
    } clint_reg_e;

    // Write strobes, at most one bit set per cycle
    typedef struct packed {
        logic                        mtime_lo_we;
        logic                        mtime_hi_we;
        logic [`CLINT_NUM_HARTS-1:0] cmp_lo_we;
        logic [`CLINT_NUM_HARTS-1:0] cmp_hi_we;
        logic [`CLINT_XLEN-1:0]      w_data;
    } clint_wr_s;

    // Read selection for the return path
    typedef struct packed {
        logic                         rd_en;
        clint_reg_e                   kind;
        logic [`CLINT_HART_WIDTH-1:0] hart;
    } clint_rd_s;

endpackage

`default_nettype wire

// ==== clint/clint_bus_decode.sv ====
// ----------------------------------------
// Request qualify, ack register and offset decode
// Address bits above CLINT_ADDR_WIDTH are ignored
// A held request is accepted every other cycle
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module clint_bus_decode (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire clint_pkg::dbus2peri_s  dbus2clint_i,
    input  wire logic                   sel_i,
    output clint_pkg::clint_wr_s        wr_o,
    output clint_pkg::clint_rd_s        rd_o,
    output logic                        ack_o
);

    // ----------------------------------------
    // Accept and ack
    // ----------------------------------------

    logic ack_q;
    logic accept;

    // No new request while ack is out
    assign accept = dbus2clint_i.req & sel_i & ~ack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            // Single-cycle pulse after each accept
            ack_q <= accept;
        end
    end

    assign ack_o = ack_q;

    // ----------------------------------------
    // Offset decode
    // ----------------------------------------

    logic [`CLINT_ADDR_WIDTH-1:0]  ofs;
    logic [`CLINT_ADDR_WIDTH-1:0]  cmp_rel;
    logic [`CLINT_ADDR_WIDTH-4:0]  cmp_idx;
    logic [`CLINT_HART_WIDTH-1:0]  hart;
    clint_pkg::clint_reg_e         kind;

    assign ofs     = dbus2clint_i.addr[`CLINT_ADDR_WIDTH-1:0];
    // Offset relative to hart 0 low word, 8 bytes per hart
    assign cmp_rel = ofs - `CLINT_ADDR_WIDTH'(`CLINT_CMP_BASE_OFS);
    assign cmp_idx = cmp_rel[`CLINT_ADDR_WIDTH-1:3];

    always_comb begin
        kind = clint_pkg::REG_NONE;
        hart = '0;
        // Unaligned offsets stay unmapped
        if (ofs[1:0] == 2'b00) begin
            if (ofs == `CLINT_ADDR_WIDTH'(`CLINT_MTIME_LO_OFS)) begin
                kind = clint_pkg::REG_MTIME_LO;
            end else if (ofs == `CLINT_ADDR_WIDTH'(`CLINT_MTIME_HI_OFS)) begin
                kind = clint_pkg::REG_MTIME_HI;
            end else if ((ofs >= `CLINT_ADDR_WIDTH'(`CLINT_CMP_BASE_OFS)) &&
                         (cmp_idx < `CLINT_NUM_HARTS)) begin
                // Bit 2 picks the high word
                kind = cmp_rel[2] ? clint_pkg::REG_CMP_HI : clint_pkg::REG_CMP_LO;
                hart = cmp_idx[`CLINT_HART_WIDTH-1:0];
            end
        end
    end

    // ----------------------------------------
    // Write strobes and read selection
    // ----------------------------------------

    always_comb begin
        wr_o        = '0;
        wr_o.w_data = dbus2clint_i.w_data;
        if (accept && dbus2clint_i.w_en) begin
            case (kind)
                clint_pkg::REG_MTIME_LO: wr_o.mtime_lo_we     = 1'b1;
                clint_pkg::REG_MTIME_HI: wr_o.mtime_hi_we     = 1'b1;
                clint_pkg::REG_CMP_LO:   wr_o.cmp_lo_we[hart] = 1'b1;
                clint_pkg::REG_CMP_HI:   wr_o.cmp_hi_we[hart] = 1'b1;
                // Unmapped write, acked and dropped
                default: ;
            endcase
        end
    end

    // Read return registers on the same edge as ack
    assign rd_o.rd_en = accept & ~dbus2clint_i.w_en;
    assign rd_o.kind  = kind;
    assign rd_o.hart  = hart;

endmodule

`default_nettype wire

// ==== clint/clint_mtime.sv ====
// ----------------------------------------
// Shared machine timer with clk-domain prescaler
// Bus write to a half wins over that edge's tick
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module clint_mtime (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire clint_pkg::clint_wr_s  wr_i,
    output logic [63:0]                mtime_o
);

    localparam int PRESC_W = $clog2(`CLINT_PRESCALE);

    // ----------------------------------------
    // Prescaler
    // ----------------------------------------

    logic [PRESC_W-1:0] presc_q;
    logic               tick;

    // Last count of the period
    assign tick = (presc_q == PRESC_W'(`CLINT_PRESCALE - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_q <= '0;
        end else if (tick) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    // ----------------------------------------
    // mtime register
    // ----------------------------------------

    logic [63:0] mtime_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= `CLINT_MTIME_RESET;
        end else if (wr_i.mtime_lo_we) begin
            // Increment dropped on a write edge
            mtime_q[`CLINT_XLEN-1:0] <= wr_i.w_data;
        end else if (wr_i.mtime_hi_we) begin
            mtime_q[2*`CLINT_XLEN-1:`CLINT_XLEN] <= wr_i.w_data;
        end else if (tick) begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    // Straight to CSR file and compare units
    assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// ==== clint/clint_hart_timer.sv ====
// ----------------------------------------
// Per-hart mtimecmp and timer interrupt
// irq follows the compare one edge late
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module clint_hart_timer (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   cmp_lo_we_i,
    input  wire logic                   cmp_hi_we_i,
    input  wire logic [`CLINT_XLEN-1:0] w_data_i,
    input  wire logic [63:0]            mtime_i,
    output logic [63:0]                 mtimecmp_o,
    output logic                        irq_o
);

    logic [63:0] mtimecmp_q;
    logic        irq_q;

    // ----------------------------------------
    // Compare register
    // ----------------------------------------

    // All ones at reset, nothing pending
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= `CLINT_CMP_RESET;
        end else if (cmp_lo_we_i) begin
            mtimecmp_q[`CLINT_XLEN-1:0] <= w_data_i;
        end else if (cmp_hi_we_i) begin
            mtimecmp_q[2*`CLINT_XLEN-1:`CLINT_XLEN] <= w_data_i;
        end
    end

    // ----------------------------------------
    // Interrupt
    // ----------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else begin
            // Level, drops when mtimecmp moves past mtime
            irq_q <= (mtime_i >= mtimecmp_q);
        end
    end

    assign mtimecmp_o = mtimecmp_q;
    assign irq_o      = irq_q;

endmodule

`default_nettype wire

// ==== clint/clint_read_return.sv ====
// ----------------------------------------
// Read data mux and return register
// Zero outside the ack cycle and for unmapped reads
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module clint_read_return (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire clint_pkg::clint_rd_s  rd_i,
    input  wire logic [63:0]           mtime_i,
    input  wire logic [63:0]           mtimecmp_i [`CLINT_NUM_HARTS],
    output logic [`CLINT_XLEN-1:0]     r_data_o
);

    logic [`CLINT_XLEN-1:0] r_data_d;
    logic [`CLINT_XLEN-1:0] r_data_q;
    logic [63:0]            cmp_sel;

    // Addressed hart, index already range checked by decode
    assign cmp_sel = mtimecmp_i[rd_i.hart];

    // ----------------------------------------
    // Half-word select
    // ----------------------------------------

    always_comb begin
        r_data_d = '0;
        if (rd_i.rd_en) begin
            case (rd_i.kind)
                clint_pkg::REG_MTIME_LO: r_data_d = mtime_i[`CLINT_XLEN-1:0];
                clint_pkg::REG_MTIME_HI: r_data_d = mtime_i[2*`CLINT_XLEN-1:`CLINT_XLEN];
                clint_pkg::REG_CMP_LO:   r_data_d = cmp_sel[`CLINT_XLEN-1:0];
                clint_pkg::REG_CMP_HI:   r_data_d = cmp_sel[2*`CLINT_XLEN-1:`CLINT_XLEN];
                // Unmapped read returns zero
                default:                 r_data_d = '0;
            endcase
        end
    end

    // ----------------------------------------
    // Return register
    // ----------------------------------------

    // Loads on the accept edge, so data lines up with ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r_data_q <= '0;
        end else begin
            r_data_q <= r_data_d;
        end
    end

    assign r_data_o = r_data_q;

endmodule

`default_nettype wire

// ==== rtl/clint_top.sv ====
// ----------------------------------------
// CLINT top, shared mtime and per-hart timer irqs
// No msip and no bus error response
// mtime_o is the full 64-bit value for rdtime
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module clint_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire clint_pkg::dbus2peri_s  dbus2clint_i,
    input  wire logic                   clint_sel_i,
    output clint_pkg::peri2dbus_s       clint2dbus_o,
    output logic [63:0]                 mtime_o,
    output logic [`CLINT_NUM_HARTS-1:0] timer_irq_o
);

    clint_pkg::clint_wr_s    wr;
    clint_pkg::clint_rd_s    rd;
    logic                    ack;
    logic [`CLINT_XLEN-1:0]  r_data;
    logic [63:0]             mtime;
    logic [63:0]             mtimecmp [`CLINT_NUM_HARTS];

    // ----------------------------------------
    // Bus side
    // ----------------------------------------

    clint_bus_decode u_bus_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus2clint_i (dbus2clint_i),
        .sel_i        (clint_sel_i),
        .wr_o         (wr),
        .rd_o         (rd),
        .ack_o        (ack)
    );

    // Shared timer
    clint_mtime u_mtime (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_i    (wr),
        .mtime_o (mtime)
    );

    // ----------------------------------------
    // One compare unit per hart
    // ----------------------------------------

    for (genvar h = 0; h < `CLINT_NUM_HARTS; h++) begin : g_hart
        clint_hart_timer u_hart_timer (
            .clk         (clk),
            .rst_n       (rst_n),
            .cmp_lo_we_i (wr.cmp_lo_we[h]),
            .cmp_hi_we_i (wr.cmp_hi_we[h]),
            .w_data_i    (wr.w_data),
            .mtime_i     (mtime),
            .mtimecmp_o  (mtimecmp[h]),
            .irq_o       (timer_irq_o[h])
        );
    end

    // Read data back to the bus
    clint_read_return u_read_return (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_i       (rd),
        .mtime_i    (mtime),
        .mtimecmp_i (mtimecmp),
        .r_data_o   (r_data)
    );

    assign clint2dbus_o.ack    = ack;
    assign clint2dbus_o.r_data = r_data;
    assign mtime_o             = mtime;

endmodule

`default_nettype wire

// ==== bench/tb_clint_top.sv ====
// ----------------------------------------
// CLINT testbench, table of bus ops run in a loop
// Model tracks ack, r_data, mtime, mtimecmp and irq per edge
// Offsets in the table stay inside the 64-byte window
// ----------------------------------------
`default_nettype none

`include "clint_consts.svh"

module tb_clint_top;

    localparam int NH       = `CLINT_NUM_HARTS;
    // Worst cycles of one plain table op
    localparam int OP_CYC   = 10;
    localparam int WAIT_CYC = 50;
    // About 8 ticks of headroom for the irq to rise
    localparam int IRQ_WAIT = 300;

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_NOSEL, OP_HOLD, OP_WAIT, OP_IRQ} op_e;

    // One table row, exp is used when chk is set
    typedef struct packed {
        op_e         op;
        logic [7:0]  ofs;
        logic [31:0] data;
        logic        rnd;
        logic [31:0] exp;
        logic        chk;
    } op_s;

    logic                  clk;
    logic                  rst_n;
    clint_pkg::dbus2peri_s bus_req;
    logic                  sel;
    clint_pkg::peri2dbus_s bus_rsp;
    logic [63:0]           mtime;
    logic [NH-1:0]         irq;

    // Reference model state
    int unsigned   edges;
    logic          ack_m;
    logic [31:0]   rdata_m;
    logic [63:0]   mtime_m;
    logic [63:0]   cmp_m [NH];
    logic [NH-1:0] irq_m;
    logic          accept_m;
    logic          tick_m;
    logic [5:0]    ofs_m;
    int            kind_m;
    int            hart_m;
    logic [31:0]   rd_val;

    int unsigned   cycles = 0;
    int unsigned   cycle_limit;
    logic [15:0]   lfsr_q;
    op_s           ops [$];

    clint_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .dbus2clint_i (bus_req),
        .clint_sel_i  (sel),
        .clint2dbus_o (bus_rsp),
        .mtime_o      (mtime),
        .timer_irq_o  (irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w[i]   = lfsr_q[0];
        end
    endtask

    // Register map, 0 mtime lo, 1 mtime hi, 2 cmp lo, 3 cmp hi, 4 unmapped
    function automatic int reg_kind(input logic [5:0] ofs);
        if (ofs[1:0] != 2'b00) begin
            return 4;
        end
        if (ofs == 6'h00) begin
            return 0;
        end
        if (ofs == 6'h04) begin
            return 1;
        end
        if (ofs >= 6'h08 && ofs < 6'(8 + 8 * NH)) begin
            return ofs[2] ? 3 : 2;
        end
        return 4;
    endfunction

    function automatic op_s mk(input op_e op, input logic [7:0] ofs, input logic [31:0] data,
                               input logic rnd, input logic [31:0] exp, input logic chk);
        return '{op, ofs, data, rnd, exp, chk};
    endfunction

    // Single request pulse, returns data seen with the ack
    task automatic bus_op(input logic wr, input logic [7:0] ofs, input logic [31:0] data,
                          output logic [31:0] rdata);
        @(posedge clk);
        bus_req.req    <= 1'b1;
        bus_req.w_en   <= wr;
        bus_req.addr   <= {24'h0, ofs};
        bus_req.w_data <= data;
        sel            <= 1'b1;
        @(posedge clk);
        bus_req.req <= 1'b0;
        @(posedge clk);
        while (bus_rsp.ack !== 1'b1) begin
            @(posedge clk);
        end
        rdata = bus_rsp.r_data;
    endtask

    task automatic count_acks(input int n, inout int acks);
        repeat (n) begin
            @(posedge clk);
            if (bus_rsp.ack === 1'b1) begin
                acks++;
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    function automatic void build_table();
        // Reset values of every mtimecmp half
        for (int h = 0; h < NH; h++) begin
            ops.push_back(mk(OP_RD, 8'(8 + 8 * h), 0, 0, 32'hFFFF_FFFF, 1));
            ops.push_back(mk(OP_RD, 8'(12 + 8 * h), 0, 0, 32'hFFFF_FFFF, 1));
        end
        ops.push_back(mk(OP_IRQ, 8'h00, 1, 0, 0, 1));
        ops.push_back(mk(OP_RD, 8'h00, 0, 0, 0, 0));
        ops.push_back(mk(OP_RD, 8'h04, 0, 0, 0, 1));
        // Random compare values, then read all harts back
        for (int h = 0; h < NH; h++) begin
            ops.push_back(mk(OP_WR, 8'(8 + 8 * h), 0, 1, 0, 0));
            ops.push_back(mk(OP_WR, 8'(12 + 8 * h), 0, 1, 0, 0));
        end
        for (int h = 0; h < NH; h++) begin
            ops.push_back(mk(OP_RD, 8'(8 + 8 * h), 0, 0, 0, 0));
            ops.push_back(mk(OP_RD, 8'(12 + 8 * h), 0, 0, 0, 0));
        end
        // Unmapped offsets, past last hart and unaligned
        ops.push_back(mk(OP_RD, 8'h28, 0, 0, 0, 1));
        ops.push_back(mk(OP_WR, 8'h28, 32'hDEAD_BEEF, 0, 0, 0));
        ops.push_back(mk(OP_RD, 8'h0A, 0, 0, 0, 1));
        ops.push_back(mk(OP_WR, 8'h3C, 32'h1234_5678, 0, 0, 0));
        // Every compare half still holds its random value
        for (int h = 0; h < NH; h++) begin
            ops.push_back(mk(OP_RD, 8'(8 + 8 * h), 0, 0, 0, 0));
            ops.push_back(mk(OP_RD, 8'(12 + 8 * h), 0, 0, 0, 0));
        end
        // No select means no ack, held req acked every other cycle
        ops.push_back(mk(OP_NOSEL, 8'h08, 0, 0, 0, 1));
        ops.push_back(mk(OP_HOLD, 8'h08, 6, 0, 3, 1));
        // Load mtime then let it run
        ops.push_back(mk(OP_WR, 8'h04, 32'h0, 0, 0, 0));
        ops.push_back(mk(OP_WR, 8'h00, 32'h1000, 0, 0, 0));
        ops.push_back(mk(OP_RD, 8'h00, 0, 0, 0, 0));
        ops.push_back(mk(OP_WAIT, 8'h00, WAIT_CYC, 0, 0, 0));
        ops.push_back(mk(OP_RD, 8'h00, 0, 0, 0, 0));
        ops.push_back(mk(OP_RD, 8'h04, 0, 0, 0, 1));
        // Hart 2 compare a few ticks ahead, lo first keeps it above mtime
        ops.push_back(mk(OP_WR, 8'h18, 32'hFFFF_FFFF, 0, 0, 0));
        ops.push_back(mk(OP_WR, 8'h1C, 32'h0, 0, 0, 0));
        ops.push_back(mk(OP_WR, 8'h18, 32'h100C, 0, 0, 0));
        ops.push_back(mk(OP_IRQ, 8'h00, 1, 0, 0, 1));
        ops.push_back(mk(OP_IRQ, 8'h00, IRQ_WAIT, 0, 32'h4, 1));
        ops.push_back(mk(OP_WR, 8'h18, 32'hFFFF_0000, 0, 0, 0));
        ops.push_back(mk(OP_IRQ, 8'h00, 4, 0, 0, 1));
    endfunction

    // ----------------------------------------
    // Reference model, checked every edge
    // ----------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            edges   <= 0;
            ack_m   <= 1'b0;
            rdata_m <= 32'h0;
            mtime_m <= 64'h0;
            irq_m   <= '0;
            for (int h = 0; h < NH; h++) begin
                cmp_m[h] <= {64{1'b1}};
            end
        end else begin
            // Outputs before this edge
            check("ack", bus_rsp.ack, ack_m);
            check("r_data", bus_rsp.r_data, rdata_m);
            check("mtime_o", mtime, mtime_m);
            check("timer_irq_o", irq, irq_m);
            accept_m = bus_req.req & sel & ~ack_m;
            ofs_m    = bus_req.addr[5:0];
            kind_m   = reg_kind(ofs_m);
            hart_m   = int'((ofs_m - 6'd8) >> 3);
            // This edge is number edges+1 since reset
            tick_m   = ((edges + 1) % `CLINT_PRESCALE) == 0;
            case (kind_m)
                0: rd_val = mtime_m[31:0];
                1: rd_val = mtime_m[63:32];
                2: rd_val = cmp_m[hart_m][31:0];
                3: rd_val = cmp_m[hart_m][63:32];
                default: rd_val = 32'h0;
            endcase
            edges   <= edges + 1;
            ack_m   <= accept_m;
            rdata_m <= (accept_m && !bus_req.w_en) ? rd_val : 32'h0;
            for (int h = 0; h < NH; h++) begin
                irq_m[h] <= (mtime_m >= cmp_m[h]);
            end
            if (accept_m && bus_req.w_en && kind_m == 0) begin
                mtime_m[31:0] <= bus_req.w_data;
            end else if (accept_m && bus_req.w_en && kind_m == 1) begin
                mtime_m[63:32] <= bus_req.w_data;
            end else if (tick_m) begin
                mtime_m <= mtime_m + 64'd1;
            end
            if (accept_m && bus_req.w_en && kind_m == 2) begin
                cmp_m[hart_m][31:0] <= bus_req.w_data;
            end
            if (accept_m && bus_req.w_en && kind_m == 3) begin
                cmp_m[hart_m][63:32] <= bus_req.w_data;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $fatal(1, "run stopped by timeout");
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        logic [31:0] rdata;
        logic [31:0] wdata;
        int          acks;
        int          n;
        op_s         o;

        rst_n   = 1'b0;
        bus_req = '0;
        sel     = 1'b0;
        lfsr_q  = 16'd7569;
        build_table();
        cycle_limit = ops.size() * OP_CYC + WAIT_CYC + IRQ_WAIT + 20;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        foreach (ops[i]) begin
            o = ops[i];
            case (o.op)
                OP_WR: begin
                    wdata = o.data;
                    if (o.rnd) begin
                        rand_word(wdata);
                    end
                    bus_op(1'b1, o.ofs, wdata, rdata);
                end
                OP_RD: begin
                    bus_op(1'b0, o.ofs, 32'h0, rdata);
                    if (o.chk) begin
                        check($sformatf("read of offset %0h", o.ofs), rdata, o.exp);
                    end
                end
                OP_NOSEL: begin
                    acks = 0;
                    @(posedge clk);
                    bus_req.req  <= 1'b1;
                    bus_req.w_en <= 1'b0;
                    bus_req.addr <= {24'h0, o.ofs};
                    sel          <= 1'b0;
                    count_acks(1, acks);
                    bus_req.req <= 1'b0;
                    sel         <= 1'b1;
                    count_acks(2, acks);
                    check("acks without select", acks, o.exp);
                end
                OP_HOLD: begin
                    acks = 0;
                    @(posedge clk);
                    bus_req.req  <= 1'b1;
                    bus_req.w_en <= 1'b0;
                    bus_req.addr <= {24'h0, o.ofs};
                    sel          <= 1'b1;
                    count_acks(o.data, acks);
                    bus_req.req <= 1'b0;
                    count_acks(2, acks);
                    check("acks for held request", acks, o.exp);
                end
                OP_WAIT: begin
                    repeat (o.data) @(posedge clk);
                end
                OP_IRQ: begin
                    n = 0;
                    do begin
                        @(posedge clk);
                        n++;
                    end while (irq !== o.exp[NH-1:0] && n < o.data);
                    check("timer_irq_o level", irq, o.exp[NH-1:0]);
                end
                default: ;
            endcase
        end

        repeat (2) @(posedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/clint_pkg.sv
clint/clint_bus_decode.sv
clint/clint_mtime.sv
clint/clint_hart_timer.sv
clint/clint_read_return.sv
rtl/clint_top.sv
bench/tb_clint_top.sv
